//--- project.f
source/pulse_pkg.sv
source/cmd_pkg.sv
source/pulse_dispatch.sv
source/pulse_element.sv
source/pulse_sum.sv
source/pulse_gen_top.sv
dv/pulse_gen_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the pulse generator testbench

VERILATOR ?= verilator
TOP ?= pulse_gen_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The simulator's exit status is not used; the pass text in its output decides
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- source/env_table.hex
// One signed 16-bit envelope word per line, addresses 0 to 63
0100
03A0
0640
08E0
0B80
0E20
10C0
1360
1600
18A0
1B40
1DE0
2080
2320
25C0
2860
2B00
2DA0
3040
32E0
3580
3820
3AC0
3D60
4000
42A0
4540
47E0
4A80
4D20
4FC0
5260
5500
57A0
5A40
5CE0
5F80
6220
64C0
6760
6A00
6CA0
6F40
71E0
7480
7720
79C0
7C60
7C00
7380
6B00
6280
5A00
5180
4900
4080
3800
2F80
2700
1E80
1600
0D80
0500
FC80

//--- source/carrier_table.hex
// One signed 16-bit cosine word per line, 32 entries over one carrier period
7FFF
7D89
7641
6A6D
5A82
471C
30FB
18F9
0000
E707
CF05
B8E4
A57E
9593
89BF
8277
8001
8277
89BF
9593
A57E
B8E4
CF05
E707
0000
18F9
30FB
471C
5A82
6A6D
7641
7D89

//--- dv/pulse_gen_tb.sv
// Testbench for the pulse generator: directed tests checked against a sample-rule model
module pulse_gen_tb;

	localparam int N_ELEM = 4;
	localparam int SPAN = 128;
	localparam int CYCLE_LIMIT = 2000;
	localparam int IDLE_WAIT = 40;

	logic elem = 1'b0;
	logic rst;
	logic cmd_stb;
	cmd_pkg::elem_id_t cmd_elem;
	cmd_pkg::env_addr_t cmd_env_start;
	cmd_pkg::env_len_t cmd_env_len;
	pulse_pkg::amp_t cmd_amp;
	pulse_pkg::phase_t cmd_freq;
	pulse_pkg::phase_t cmd_phase;
	logic cmd_err;
	logic valid_out;
	pulse_pkg::sample_t out_x;
	pulse_pkg::sample_t out_y;
	logic busy;

	pulse_pkg::sample_t env_tab [64];
	pulse_pkg::sample_t car_tab [32];

	// Command schedule and expected response, indexed by cycle within a test
	logic sch_stb [SPAN];
	cmd_pkg::elem_id_t sch_elem [SPAN];
	cmd_pkg::env_addr_t sch_start [SPAN];
	cmd_pkg::env_len_t sch_len [SPAN];
	pulse_pkg::amp_t sch_amp [SPAN];
	pulse_pkg::phase_t sch_freq [SPAN];
	pulse_pkg::phase_t sch_phase [SPAN];
	logic exp_valid [SPAN];
	logic exp_err [SPAN];
	logic exp_busy [SPAN];
	pulse_pkg::sample_t exp_x [SPAN];
	pulse_pkg::sample_t exp_y [SPAN];

	logic [15:0] lfsr_state;
	int cycles = 0;
	int checks;
	int errors;

	pulse_gen_top #(.N_ELEM(N_ELEM)) i_pulse_gen_top (
		.elem(elem), .rst(rst), .cmd_stb(cmd_stb), .cmd_elem(cmd_elem),
		.cmd_env_start(cmd_env_start), .cmd_env_len(cmd_env_len), .cmd_amp(cmd_amp),
		.cmd_freq(cmd_freq), .cmd_phase(cmd_phase), .cmd_err(cmd_err),
		.valid_out(valid_out), .out_x(out_x), .out_y(out_y), .busy(busy)
	);

	always #50 elem = ~elem;

	always @(posedge elem) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Sample k of one element; sine is the cosine table a quarter period back
	function automatic pulse_pkg::sample_t model_sample(cmd_pkg::env_addr_t a0, int k, bit cw,
			pulse_pkg::amp_t a, pulse_pkg::phase_t f, pulse_pkg::phase_t p, bit want_y);
		logic [5:0] addr;
		pulse_pkg::phase_t ph;
		logic [4:0] idx;
		pulse_pkg::sample_t env;
		pulse_pkg::sample_t car;
		pulse_pkg::sample_t e;
		logic signed [31:0] prod;
		addr = 6'((int'(a0) + k) % 64);
		ph = p + pulse_pkg::phase_t'(k) * f;
		idx = ph[15:11];
		if (want_y) begin
			idx = idx - 5'd8;
		end
		env = cw ? 16'sh7fff : env_tab[addr];
		car = car_tab[idx];
		prod = env * a;
		e = prod[30:15];
		prod = e * car;
		return prod[30:15];
	endfunction

	task automatic clear_schedule();
		for (int n = 0; n < SPAN; n++) begin
			sch_stb[n] = 1'b0;
			exp_valid[n] = 1'b0;
			exp_err[n] = 1'b0;
			exp_busy[n] = 1'b0;
			exp_x[n] = '0;
			exp_y[n] = '0;
		end
	endtask

	task automatic schedule_cmd(input int at, input cmd_pkg::elem_id_t id,
			input cmd_pkg::env_addr_t a0, input cmd_pkg::env_len_t len,
			input pulse_pkg::amp_t a, input pulse_pkg::phase_t f, input pulse_pkg::phase_t p);
		sch_stb[at] = 1'b1;
		sch_elem[at] = id;
		sch_start[at] = a0;
		sch_len[at] = len;
		sch_amp[at] = a;
		sch_freq[at] = f;
		sch_phase[at] = p;
		if (int'(id) >= N_ELEM) begin
			exp_err[at + 1] = 1'b1;
		end
	endtask

	// Adds one element's samples into the expected output, wrapping at 16 bits
	task automatic add_samples(input int first, input int count, input cmd_pkg::env_addr_t a0,
			input bit cw, input pulse_pkg::amp_t a, input pulse_pkg::phase_t f,
			input pulse_pkg::phase_t p);
		// Busy shows two cycles after the command and lasts through the last output sample
		for (int n = first - 5; n < first + count; n++) begin
			exp_busy[n] = 1'b1;
		end
		for (int k = 0; k < count; k++) begin
			exp_valid[first + k] = 1'b1;
			exp_x[first + k] = exp_x[first + k] + model_sample(a0, k, cw, a, f, p, 1'b0);
			exp_y[first + k] = exp_y[first + k] + model_sample(a0, k, cw, a, f, p, 1'b1);
		end
	endtask

	task automatic compare_outputs(input string name, input int n);
		checks++;
		assert (valid_out === exp_valid[n]) else begin
			errors++;
			$display("Fail %s valid_out at cycle %0d: expected %0b, actual %0b",
				name, n, exp_valid[n], valid_out);
		end
		assert (cmd_err === exp_err[n]) else begin
			errors++;
			$display("Fail %s cmd_err at cycle %0d: expected %0b, actual %0b",
				name, n, exp_err[n], cmd_err);
		end
		assert (busy === exp_busy[n]) else begin
			errors++;
			$display("Fail %s busy at cycle %0d: expected %0b, actual %0b",
				name, n, exp_busy[n], busy);
		end
		if (exp_valid[n]) begin
			assert (out_x === exp_x[n]) else begin
				errors++;
				$display("Fail %s out_x at cycle %0d: expected %0d, actual %0d",
					name, n, exp_x[n], out_x);
			end
			assert (out_y === exp_y[n]) else begin
				errors++;
				$display("Fail %s out_y at cycle %0d: expected %0d, actual %0d",
					name, n, exp_y[n], out_y);
			end
		end
	endtask

	// Checks the outputs at each falling edge, then drives that cycle's command
	task automatic play_schedule(input string name, input int length);
		for (int n = 0; n < length; n++) begin
			@(negedge elem);
			compare_outputs(name, n);
			cmd_stb = sch_stb[n];
			if (sch_stb[n]) begin
				cmd_elem = sch_elem[n];
				cmd_env_start = sch_start[n];
				cmd_env_len = sch_len[n];
				cmd_amp = sch_amp[n];
				cmd_freq = sch_freq[n];
				cmd_phase = sch_phase[n];
			end
		end
		@(negedge elem);
		cmd_stb = 1'b0;
	endtask

	task automatic wait_until_idle(input string name);
		int n;
		n = 0;
		while (busy !== 1'b0 && n < IDLE_WAIT) begin
			@(negedge elem);
			n++;
		end
		assert (busy === 1'b0) else begin
			errors++;
			$display("%s: the generator was still busy %0d cycles after the test", name, n);
		end
	endtask

	task automatic idle_after_reset();
		clear_schedule();
		for (int n = 0; n < 20; n++) begin
			@(negedge elem);
			compare_outputs("idle_after_reset", n);
		end
	endtask

	// Start address 58 with 12 samples runs through the top of the table
	task automatic shaped_pulse_wrap();
		pulse_pkg::amp_t a;
		pulse_pkg::phase_t f;
		a = rand_bits(16);
		f = rand_bits(16);
		clear_schedule();
		schedule_cmd(0, 4'd0, 6'd58, 7'd12, a, f, 16'h1234);
		add_samples(7, 12, 6'd58, 1'b0, a, f, 16'h1234);
		play_schedule("shaped_pulse_wrap", 24);
		wait_until_idle("shaped_pulse_wrap");
	endtask

	task automatic cw_then_replace();
		pulse_pkg::amp_t a1;
		pulse_pkg::amp_t a2;
		pulse_pkg::phase_t f1;
		pulse_pkg::phase_t f2;
		a1 = rand_bits(16);
		f1 = rand_bits(16);
		a2 = rand_bits(16);
		f2 = rand_bits(16);
		clear_schedule();
		schedule_cmd(0, 4'd2, 6'd0, 7'd0, a1, f1, 16'h0000);
		schedule_cmd(20, 4'd2, 6'd5, 7'd10, a2, f2, 16'h4000);
		add_samples(7, 20, 6'd0, 1'b1, a1, f1, 16'h0000);
		add_samples(27, 10, 6'd5, 1'b0, a2, f2, 16'h4000);
		play_schedule("cw_then_replace", 40);
		wait_until_idle("cw_then_replace");
	endtask

	task automatic overlapping_pulses();
		pulse_pkg::amp_t a1;
		pulse_pkg::amp_t a3;
		pulse_pkg::phase_t f1;
		pulse_pkg::phase_t f3;
		a1 = rand_bits(16);
		f1 = rand_bits(16);
		a3 = rand_bits(16);
		f3 = rand_bits(16);
		clear_schedule();
		schedule_cmd(0, 4'd1, 6'd0, 7'd64, a1, f1, 16'h0800);
		schedule_cmd(20, 4'd3, 6'd10, 7'd40, a3, f3, 16'hc000);
		add_samples(7, 64, 6'd0, 1'b0, a1, f1, 16'h0800);
		add_samples(27, 40, 6'd10, 1'b0, a3, f3, 16'hc000);
		play_schedule("overlapping_pulses", 76);
		wait_until_idle("overlapping_pulses");
	endtask

	task automatic bad_element_index();
		clear_schedule();
		schedule_cmd(0, 4'd9, 6'd0, 7'd8, rand_bits(16), rand_bits(16), 16'h0000);
		play_schedule("bad_element_index", 16);
		wait_until_idle("bad_element_index");
	endtask

	// The old pulse gives one sample per cycle between the two commands
	task automatic retrigger_busy_element();
		pulse_pkg::amp_t a1;
		pulse_pkg::amp_t a2;
		pulse_pkg::phase_t f1;
		pulse_pkg::phase_t f2;
		a1 = rand_bits(16);
		f1 = rand_bits(16);
		a2 = rand_bits(16);
		f2 = rand_bits(16);
		clear_schedule();
		schedule_cmd(0, 4'd0, 6'd0, 7'd40, a1, f1, 16'h2000);
		schedule_cmd(12, 4'd0, 6'd32, 7'd16, a2, f2, 16'h9000);
		add_samples(7, 12, 6'd0, 1'b0, a1, f1, 16'h2000);
		add_samples(19, 16, 6'd32, 1'b0, a2, f2, 16'h9000);
		play_schedule("retrigger_busy_element", 40);
		wait_until_idle("retrigger_busy_element");
	endtask

	initial begin
		rst = 1'b1;
		cmd_stb = 1'b0;
		cmd_elem = '0;
		cmd_env_start = '0;
		cmd_env_len = '0;
		cmd_amp = '0;
		cmd_freq = '0;
		cmd_phase = '0;
		lfsr_state = 16'd4;
		checks = 0;
		errors = 0;
		$readmemh("source/env_table.hex", env_tab);
		$readmemh("source/carrier_table.hex", car_tab);
		repeat (8) @(negedge elem);
		rst = 1'b0;
		idle_after_reset();
		shaped_pulse_wrap();
		cw_then_replace();
		overlapping_pulses();
		bad_element_index();
		retrigger_busy_element();
		$display("Summary: %0d cycles checked, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- source/pulse_gen_top.sv
// Multi-element pulse generator: command dispatch, N_ELEM elements and output summer
module pulse_gen_top #(
	parameter int N_ELEM = 4
) (
	input  logic                elem,
	input  logic                rst,
	input  logic                cmd_stb,
	input  cmd_pkg::elem_id_t   cmd_elem,
	input  cmd_pkg::env_addr_t  cmd_env_start,
	input  cmd_pkg::env_len_t   cmd_env_len,
	input  pulse_pkg::amp_t     cmd_amp,
	input  pulse_pkg::phase_t   cmd_freq,
	input  pulse_pkg::phase_t   cmd_phase,
	output logic                cmd_err,
	output logic                valid_out,
	output pulse_pkg::sample_t  out_x,
	output pulse_pkg::sample_t  out_y,
	output logic                busy
);

	localparam int W = pulse_pkg::SAMPLE_W;

	logic [N_ELEM-1:0] start;
	cmd_pkg::env_addr_t env_start;
	cmd_pkg::env_len_t env_len;
	pulse_pkg::amp_t amp;
	pulse_pkg::phase_t freq;
	pulse_pkg::phase_t phase;
	logic [N_ELEM-1:0] elem_valid;
	logic [N_ELEM-1:0] elem_busy;
	logic [N_ELEM*W-1:0] elem_x;
	logic [N_ELEM*W-1:0] elem_y;

	pulse_dispatch #(.N_ELEM(N_ELEM)) i_pulse_dispatch (
		.elem(elem), .rst(rst), .cmd_stb(cmd_stb), .cmd_elem(cmd_elem),
		.cmd_env_start(cmd_env_start), .cmd_env_len(cmd_env_len), .cmd_amp(cmd_amp),
		.cmd_freq(cmd_freq), .cmd_phase(cmd_phase), .start(start),
		.env_start(env_start), .env_len(env_len), .amp(amp), .freq(freq),
		.phase(phase), .cmd_err(cmd_err)
	);

	for (genvar i = 0; i < N_ELEM; i++) begin : g_elem
		pulse_element i_pulse_element (
			.elem(elem), .rst(rst), .start(start[i]), .env_start(env_start),
			.env_len(env_len), .amp(amp), .freq(freq), .phase(phase),
			.valid(elem_valid[i]), .x(elem_x[i*W +: W]), .y(elem_y[i*W +: W]),
			.busy(elem_busy[i])
		);
	end

	pulse_sum #(.N_ELEM(N_ELEM)) i_pulse_sum (
		.elem(elem), .rst(rst), .elem_valid(elem_valid), .elem_x(elem_x),
		.elem_y(elem_y), .elem_busy(elem_busy), .valid_out(valid_out),
		.out_x(out_x), .out_y(out_y), .busy(busy)
	);

endmodule

//--- source/pulse_sum.sv
// Output summer: two-level registered adder tree over all element lanes
module pulse_sum #(
	parameter int N_ELEM = 4
) (
	input  logic                                elem,
	input  logic                                rst,
	input  logic [N_ELEM-1:0]                   elem_valid,
	input  logic [N_ELEM*pulse_pkg::SAMPLE_W-1:0] elem_x,
	input  logic [N_ELEM*pulse_pkg::SAMPLE_W-1:0] elem_y,
	input  logic [N_ELEM-1:0]                   elem_busy,
	output logic                                valid_out,
	output pulse_pkg::sample_t                  out_x,
	output pulse_pkg::sample_t                  out_y,
	output logic                                busy
);

	localparam int W = pulse_pkg::SAMPLE_W;
	localparam int N_PAIR = N_ELEM / 2;

	pulse_pkg::sample_t lane_x [N_ELEM];
	pulse_pkg::sample_t lane_y [N_ELEM];
	pulse_pkg::sample_t pair_x [N_PAIR];
	pulse_pkg::sample_t pair_y [N_PAIR];
	pulse_pkg::sample_t sum_x, sum_y;
	logic valid_d1;

	// Idle lanes contribute zero
	for (genvar i = 0; i < N_ELEM; i++) begin : g_lane
		assign lane_x[i] = elem_valid[i] ? elem_x[i*W +: W] : '0;
		assign lane_y[i] = elem_valid[i] ? elem_y[i*W +: W] : '0;
	end

	always_ff @(posedge elem) begin
		for (int j = 0; j < N_PAIR; j++) begin
			pair_x[j] <= lane_x[2*j] + lane_x[2*j+1];
			pair_y[j] <= lane_y[2*j] + lane_y[2*j+1];
		end
	end

	// Sums wrap at the sample width
	always_comb begin
		sum_x = '0;
		sum_y = '0;
		for (int j = 0; j < N_PAIR; j++) begin
			sum_x = sum_x + pair_x[j];
			sum_y = sum_y + pair_y[j];
		end
	end

	always_ff @(posedge elem) begin
		out_x <= sum_x;
		out_y <= sum_y;
	end

	always_ff @(posedge elem) begin
		if (rst) begin
			valid_d1 <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			valid_d1 <= |elem_valid;
			valid_out <= valid_d1;
		end
	end

	assign busy = |elem_busy || valid_d1 || valid_out;

endmodule

//--- source/pulse_element.sv
// Pulse element: envelope sequencer, carrier oscillator and I/Q multiply pipeline
module pulse_element (
	input  logic                elem,
	input  logic                rst,
	input  logic                start,
	input  cmd_pkg::env_addr_t  env_start,
	input  cmd_pkg::env_len_t   env_len,
	input  pulse_pkg::amp_t     amp,
	input  pulse_pkg::phase_t   freq,
	input  pulse_pkg::phase_t   phase,
	output logic                valid,
	output pulse_pkg::sample_t  x,
	output pulse_pkg::sample_t  y,
	output logic                busy
);

	pulse_pkg::sample_t env_mem [pulse_pkg::ENV_DEPTH];
	pulse_pkg::sample_t carrier_mem [pulse_pkg::CARRIER_DEPTH];

	cmd_pkg::elem_state_t state;
	cmd_pkg::env_addr_t addr_q;
	cmd_pkg::env_len_t remain;
	pulse_pkg::phase_t phase_acc;
	pulse_pkg::phase_t freq_r;
	pulse_pkg::amp_t amp_r;
	pulse_pkg::carrier_idx_t cos_idx;
	pulse_pkg::carrier_idx_t sin_idx;
	logic run;
	logic last0;

	logic v1, v2, l1, l2, last_q;
	pulse_pkg::sample_t env_q, cos_q, sin_q, cos_q2, sin_q2, e_q;
	pulse_pkg::amp_t amp_s1;
	logic signed [31:0] env_prod, x_prod, y_prod;

	initial begin
		$readmemh("source/env_table.hex", env_mem);
		$readmemh("source/carrier_table.hex", carrier_mem);
	end

	assign run = state != cmd_pkg::state_idle;
	assign last0 = state == cmd_pkg::state_shaped && remain == 7'd1;
	assign cos_idx = phase_acc[15:11];
	// Sine lags cosine by a quarter period
	assign sin_idx = cos_idx - 5'(pulse_pkg::CARRIER_QUARTER);

	// Sequencer: envelope address, phase accumulator and remaining sample count
	always_ff @(posedge elem) begin
		if (rst) begin
			state <= cmd_pkg::state_idle;
		end else if (start) begin
			state <= (env_len == '0) ? cmd_pkg::state_cw : cmd_pkg::state_shaped;
		end else if (last0) begin
			state <= cmd_pkg::state_idle;
		end
	end

	always_ff @(posedge elem) begin
		if (start) begin
			addr_q <= env_start;
			phase_acc <= phase;
			freq_r <= freq;
			amp_r <= amp;
			remain <= env_len;
		end else if (run) begin
			addr_q <= addr_q + 1'b1;
			phase_acc <= phase_acc + freq_r;
			remain <= remain - 1'b1;
		end
	end

	assign env_prod = env_q * amp_s1;
	assign x_prod = e_q * cos_q2;
	assign y_prod = e_q * sin_q2;

	// Table read, envelope scaling, then carrier mixing
	always_ff @(posedge elem) begin
		env_q <= (state == cmd_pkg::state_cw) ? pulse_pkg::ENV_FULL : env_mem[addr_q];
		cos_q <= carrier_mem[cos_idx];
		sin_q <= carrier_mem[sin_idx];
		amp_s1 <= amp_r;
		e_q <= pulse_pkg::sample_t'(env_prod >>> 15);
		cos_q2 <= cos_q;
		sin_q2 <= sin_q;
		x <= pulse_pkg::sample_t'(x_prod >>> 15);
		y <= pulse_pkg::sample_t'(y_prod >>> 15);
	end

	// Samples of an abandoned pulse drain out, but their last flags must not end the new one
	always_ff @(posedge elem) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			valid <= 1'b0;
			l1 <= 1'b0;
			l2 <= 1'b0;
			last_q <= 1'b0;
		end else begin
			v1 <= run;
			v2 <= v1;
			valid <= v2;
			l1 <= last0 && !start;
			l2 <= l1 && !start;
			last_q <= l2 && !start;
		end
	end

	always_ff @(posedge elem) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (valid && last_q) begin
			busy <= 1'b0;
		end
	end

	a_idle_no_valid: assert property (@(posedge elem) disable iff (rst)
		(state == cmd_pkg::state_idle && !start) |-> ##4 !valid);

	a_valid_busy: assert property (@(posedge elem) disable iff (rst)
		valid |-> busy);

endmodule

//--- source/pulse_dispatch.sv
// Command dispatcher: registers host commands and strobes the addressed element
module pulse_dispatch #(
	parameter int N_ELEM = 4
) (
	input  logic                elem,
	input  logic                rst,
	input  logic                cmd_stb,
	input  cmd_pkg::elem_id_t   cmd_elem,
	input  cmd_pkg::env_addr_t  cmd_env_start,
	input  cmd_pkg::env_len_t   cmd_env_len,
	input  pulse_pkg::amp_t     cmd_amp,
	input  pulse_pkg::phase_t   cmd_freq,
	input  pulse_pkg::phase_t   cmd_phase,
	output logic [N_ELEM-1:0]   start,
	output cmd_pkg::env_addr_t  env_start,
	output cmd_pkg::env_len_t   env_len,
	output pulse_pkg::amp_t     amp,
	output pulse_pkg::phase_t   freq,
	output pulse_pkg::phase_t   phase,
	output logic                cmd_err
);

	logic in_range;

	assign in_range = 32'(cmd_elem) < N_ELEM;

	// One copy of the fields serves all elements; only the addressed one latches it
	always_ff @(posedge elem) begin
		if (cmd_stb) begin
			env_start <= cmd_env_start;
			env_len <= cmd_env_len;
			amp <= cmd_amp;
			freq <= cmd_freq;
			phase <= cmd_phase;
		end
	end

	always_ff @(posedge elem) begin
		if (rst) begin
			start <= '0;
			cmd_err <= 1'b0;
		end else begin
			start <= '0;
			cmd_err <= 1'b0;
			if (cmd_stb) begin
				if (in_range) begin
					start <= {{(N_ELEM-1){1'b0}}, 1'b1} << cmd_elem;
				end else begin
					cmd_err <= 1'b1;
				end
			end
		end
	end

	a_start_onehot: assert property (@(posedge elem) disable iff (rst)
		$onehot0(start));

endmodule

//--- source/cmd_pkg.sv
// Command field types and the per-element sequencer state encoding
package cmd_pkg;

	typedef logic [3:0] elem_id_t;

	typedef logic [5:0] env_addr_t;

	// Envelope length in samples; zero selects continuous-wave mode
	typedef logic [6:0] env_len_t;

	typedef enum logic [1:0] {
		state_idle,
		state_shaped,
		state_cw
	} elem_state_t;

endpackage

//--- source/pulse_pkg.sv
// Sample-path types shared by the pulse elements, the summer and the top level
package pulse_pkg;

	// Width of one real sample, also the lane width of packed element outputs
	localparam int SAMPLE_W = 16;

	// Table depths for the envelope and carrier ROMs
	localparam int ENV_DEPTH = 64;
	localparam int CARRIER_DEPTH = 32;

	// Quarter of a carrier period in table entries, used to derive sine from cosine
	localparam int CARRIER_QUARTER = 8;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef logic signed [15:0] amp_t;

	// Carrier phase and per-sample frequency step share one format
	typedef logic [15:0] phase_t;

	typedef logic [4:0] carrier_idx_t;

	// Envelope value held during continuous-wave output
	localparam sample_t ENV_FULL = 16'sh7fff;

endpackage
